//--- hackBusPkg.sv
/*
 * hackBusPkg
 * CPU-side definitions for the SPI flash peripheral of the Hack-style
 * computer. Holds the bus word and address types, the memory-mapped
 * SPI register address, and the layouts of the write and status words.
 */
package hackBusPkg;

	// cpu data path and address bus
	typedef logic [15:0] hackWord;   // one cpu data word
	typedef logic [14:0] hackAddr;   // hack addresses are 15 bits

	// SPI register sits one word above the keyboard register
	localparam hackAddr spiRegAddr = 15'h6001;

	// word written by the cpu to the SPI register
	// deselect=0 lowers csN and shifts txByte out
	// deselect=1 only raises csN
	typedef struct packed {
		logic [6:0] pad;        // ignored
		logic       deselect;   // bit 8
		logic [7:0] txByte;     // command, address or dummy byte
	} spiWrite;

	// word returned on a read of the SPI register
	typedef struct packed {
		logic       busy;       // bit 15, transfer in progress
		logic [6:0] pad;        // always zero
		logic [7:0] rxByte;     // last byte received from the flash
	} spiStatus;

endpackage

//--- spiPkg.sv
/*
 * spiPkg
 * Serial-side definitions for the W25Q16BV SPI master. Byte and counter
 * types, the transfer length, the outgoing pin bundle and the bit timer
 * state encoding.
 */
package spiPkg;

	typedef logic [7:0] spiByte;    // one byte on MOSI or MISO

	// counts clk cycles of a transfer, two per SCK period
	typedef logic [3:0] bitCount;

	// 8 SCK periods at half the clk rate
	localparam int xferCycles = 16;

	// pins driven towards the flash
	typedef struct packed {
		logic sck;    // serial clock, idles low (mode 0)
		logic csN;    // chip select, active low
		logic mosi;   // master out slave in
	} spiPins;

	// bit timer FSM
	typedef enum logic {
		IDLE  = 1'b0,
		SHIFT = 1'b1
	} timerState;

endpackage

//--- spiBitTimer.sv
/*
 * spiBitTimer
 * Busy FSM and clk cycle counter of the SPI master. A start pulse in IDLE
 * runs 16 clk cycles in SHIFT. SCK is high on odd counts, which gives 8
 * SCK periods, and shiftEn flags the cycle that ends each high phase.
 */
`timescale 1ns/1ps

module spiBitTimer (
	input  logic clk,
	input  logic rstN,
	input  logic start,     // one-cycle request, ignored while busy
	output logic busy,
	output logic sck,
	output logic shiftEn
);

	spiPkg::timerState state;
	spiPkg::bitCount   count;     // clk cycles into the transfer
	logic              lastCycle;

	assign lastCycle = (count == spiPkg::bitCount'(spiPkg::xferCycles - 1));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= spiPkg::IDLE;
			count <= '0;
		end else begin
			case (state)
				spiPkg::IDLE: begin
					count <= '0;   // first SHIFT cycle sees count 0
					if (start) begin
						state <= spiPkg::SHIFT;
					end
				end
				spiPkg::SHIFT: begin
					count <= count + 1'b1;   // wraps to 0 after 15
					if (lastCycle) begin
						state <= spiPkg::IDLE;   // busy drops after the 16th edge
					end
				end
				default: begin
					state <= spiPkg::IDLE;
				end
			endcase
		end
	end

	assign busy = (state == spiPkg::SHIFT);

	// half-rate clock, low on even counts so it starts and ends low
	assign sck = busy & count[0];

	// high phase of sck is the last cycle before its falling edge,
	// so the shifter moves on the same clk edge that drops SCK
	assign shiftEn = sck;

endmodule

//--- spiShifter.sv
/*
 * spiShifter
 * 8-bit circular shift register for full-duplex SPI. Loads the byte to
 * send, shifts left on each SCK fall with the registered MISO bit entering
 * the LSB, and drives MOSI from the MSB. After eight shifts the register
 * holds the byte received from the flash.
 */
`timescale 1ns/1ps

module spiShifter (
	input  logic           clk,
	input  logic           rstN,
	input  logic           load,      // takes txByte, wins over shiftEn
	input  spiPkg::spiByte txByte,
	input  logic           shiftEn,   // one pulse per SCK period
	input  logic           miso,
	output spiPkg::spiByte rxByte,
	output logic           mosi
);

	logic           misoQ;      // miso one clk late
	spiPkg::spiByte shiftReg;

	// flash drives miso off SCK falling, so the value is stable by
	// the time it is caught here
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			misoQ <= 1'b0;
		end else begin
			misoQ <= miso;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			shiftReg <= '0;   // status reads zero out of reset
		end else if (load) begin
			shiftReg <= txByte;
		end else if (shiftEn) begin
			shiftReg <= {shiftReg[6:0], misoQ};   // slave MSB into master LSB
		end
	end

	assign mosi   = shiftReg[7];   // master MSB out first
	assign rxByte = shiftReg;      // only complete once busy is low

endmodule

//--- spiController.sv
/*
 * spiController
 * SPI master for the W25Q16BV flash. Holds the chip-select register,
 * drops writes that arrive while a transfer runs, starts the bit timer
 * and loads the shifter for a send, and assembles the pin bundle and the
 * cpu status word.
 */
`timescale 1ns/1ps

module spiController (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 load,     // write to the SPI register
	input  hackBusPkg::spiWrite  cmd,
	input  logic                 miso,
	output spiPkg::spiPins       pins,
	output hackBusPkg::spiStatus status
);

	logic           accept;   // load that is not dropped
	logic           start;    // accepted send
	logic           csN;
	logic           busy;
	logic           sck;
	logic           shiftEn;
	logic           mosi;
	spiPkg::spiByte rxByte;

	// a write during a transfer would corrupt the shifter, drop it
	assign accept = load & ~busy;
	assign start  = accept & ~cmd.deselect;

	// csN follows bit 8 of every accepted write and holds until the next
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			csN <= 1'b1;   // flash deselected out of reset
		end else if (accept) begin
			csN <= cmd.deselect;
		end
	end

	spiBitTimer uTimer (
		.clk     (clk),
		.rstN    (rstN),
		.start   (start),
		.busy    (busy),
		.sck     (sck),
		.shiftEn (shiftEn)
	);

	// loads on the same edge that starts the timer
	spiShifter uShifter (
		.clk     (clk),
		.rstN    (rstN),
		.load    (start),
		.txByte  (cmd.txByte),
		.shiftEn (shiftEn),
		.miso    (miso),
		.rxByte  (rxByte),
		.mosi    (mosi)
	);

	assign pins = '{sck: sck, csN: csN, mosi: mosi};

	// busy in bit 15, received byte in the low half
	assign status = '{busy: busy, pad: '0, rxByte: rxByte};

endmodule

//--- spiBusPort.sv
/*
 * spiBusPort
 * Memory-mapped port of the SPI master on the Hack cpu bus. Turns a cpu
 * write to the SPI register into a registered load pulse with its command
 * word, one clk after the write, and serves status on reads.
 */
`timescale 1ns/1ps

module spiBusPort (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 memWrite,   // one-cycle write strobe
	input  hackBusPkg::hackAddr  memAddr,
	input  hackBusPkg::hackWord  memWData,
	input  hackBusPkg::spiStatus status,
	output logic                 load,
	output hackBusPkg::spiWrite  cmd,
	output hackBusPkg::hackWord  memRData
);

	logic hit;   // address matches the SPI register

	assign hit = (memAddr == hackBusPkg::spiRegAddr);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			load <= 1'b0;
		end else begin
			load <= memWrite & hit;   // single pulse per write
		end
	end

	// command word only matters while load is high
	always_ff @(posedge clk) begin
		if (memWrite && hit) begin
			cmd <= hackBusPkg::spiWrite'(memWData);
		end
	end

	// reads are combinational from the address
	assign memRData = hit ? hackBusPkg::hackWord'(status) : '0;

endmodule

//--- flashSpiTop.sv
/*
 * flashSpiTop
 * SPI flash peripheral of the Hack computer. Bus port on the cpu side,
 * SPI controller towards the W25Q16BV pins.
 */
`timescale 1ns/1ps

module flashSpiTop (
	input  logic                clk,
	input  logic                rstN,
	input  logic                memWrite,
	input  hackBusPkg::hackAddr memAddr,
	input  hackBusPkg::hackWord memWData,
	output hackBusPkg::hackWord memRData,
	input  logic                miso,
	output spiPkg::spiPins      pins
);

	logic                 load;
	hackBusPkg::spiWrite  cmd;
	hackBusPkg::spiStatus status;

	spiBusPort uBusPort (
		.clk      (clk),
		.rstN     (rstN),
		.memWrite (memWrite),
		.memAddr  (memAddr),
		.memWData (memWData),
		.status   (status),
		.load     (load),
		.cmd      (cmd),
		.memRData (memRData)
	);

	spiController uCtrl (
		.clk    (clk),
		.rstN   (rstN),
		.load   (load),
		.cmd    (cmd),
		.miso   (miso),
		.pins   (pins),
		.status (status)
	);

endmodule

//--- tbClock.sv
/*
 * tbClock
 * Clock and reset source of the SPI testbench. 40 ns clk, active-low
 * reset held for 5 cycles and released on a falling edge.
 */
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rstN
);

	localparam int halfPeriod  = 20;
	localparam int resetCycles = 5;

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);   // release away from the active edge
		rstN = 1'b1;
	end

endmodule

//--- flashModel.sv
/*
 * flashModel
 * Behavioral W25Q16BV subset for the SPI testbench. Mode 0, takes MOSI on
 * SCK rising and drives MISO on SCK falling. Decodes read data (03h) with
 * a 24-bit address and auto-increment, and JEDEC ID (9Fh). Any csN edge
 * restarts the command decode.
 */
`timescale 1ns/1ps

module flashModel (
	input  spiPkg::spiPins pins,
	output logic           miso,
	output spiPkg::spiByte lastByte,    // last complete byte from the master
	output int             byteCount    // bytes taken since time 0
);

	localparam logic [7:0] opRead  = 8'h03;
	localparam logic [7:0] opJedec = 8'h9F;

	logic [7:0]  inShift  = '0;
	logic [7:0]  outShift = '0;
	logic [7:0]  opcode   = '0;
	logic [23:0] addr     = '0;
	int          bitNum   = 0;     // bits of the byte in flight
	int          byteNum  = 0;     // bytes since csN last moved
	logic        prevCsN  = 1'b1;
	logic        prevSck  = 1'b0;
	logic        misoOut  = 1'b0;
	logic [7:0]  rxLast   = '0;
	int          rxCount  = 0;

	assign miso      = misoOut;
	assign lastByte  = rxLast;
	assign byteCount = rxCount;

	function automatic logic [7:0] jedecByte(input int idx);
		case (idx)
			0:       return 8'hEF;   // manufacturer
			1:       return 8'h40;   // memory type
			2:       return 8'h15;   // capacity, 16 Mbit
			default: return 8'h00;
		endcase
	endfunction

	always @(pins) begin
		if (pins.csN != prevCsN) begin
			bitNum  = 0;   // select or deselect, start a new command
			byteNum = 0;
			opcode  = '0;
			misoOut = 1'b0;
		end else if (!pins.csN && pins.sck && !prevSck) begin
			inShift = {inShift[6:0], pins.mosi};   // MSB first
			bitNum++;
			if (bitNum == 8) begin
				bitNum = 0;
				rxLast = inShift;
				rxCount++;
				if (byteNum == 0) begin
					opcode = inShift;
				end else if (byteNum <= 3) begin
					addr = {addr[15:0], inShift};   // address high byte first
				end
				byteNum++;
			end
		end else if (!pins.csN && !pins.sck && prevSck) begin
			// on a byte boundary the next byte goes out MSB first
			if (bitNum == 0) begin
				if (opcode == opJedec) begin
					outShift = jedecByte(byteNum - 1);
				end else if (opcode == opRead && byteNum >= 4) begin
					outShift = addr[7:0] ^ 8'hA5;   // data pattern of the model
					addr++;
				end else begin
					outShift = '0;   // command and address phase
				end
			end else begin
				outShift = {outShift[6:0], 1'b0};
			end
			misoOut = outShift[7];
		end
		prevCsN = pins.csN;
		prevSck = pins.sck;
	end

endmodule

//--- spiProperties_properties.sv
/*
 * spiProperties
 * Concurrent checks on the SPI pins and status word, bound into
 * flashSpiTop. Reset values, 16-cycle busy with 8 SCK edges, MOSI timing,
 * csN held during a transfer and a quiet bus while deselected.
 */
`timescale 1ns/1ps

module spiProperties (
	input logic                 clk,
	input logic                 rstN,
	input spiPkg::spiPins       pins,
	input hackBusPkg::spiStatus status
);

	int   failCount = 0;   // failed assertions, read by the testbench
	int   sckEdges;        // SCK rising edges in the current transfer
	int   busyLen;         // cycles with busy high
	logic sckQ;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			sckQ     <= 1'b0;
			sckEdges <= 0;
			busyLen  <= 0;
		end else begin
			sckQ <= pins.sck;
			if (!status.busy) begin
				sckEdges <= 0;
				busyLen  <= 0;
			end else begin
				busyLen <= busyLen + 1;
				if (pins.sck && !sckQ) begin
					sckEdges <= sckEdges + 1;
				end
			end
		end
	end

	// second edge of reset on, when the async clear has surely landed
	resetValues: assert property (@(posedge clk)
		!rstN ##1 !rstN |-> pins.csN && !pins.sck && !pins.mosi && status == '0)
		else begin failCount++; $error("pins or status wrong during reset"); end

	firstCycle: assert property (@(posedge clk)
		$rose(rstN) |-> pins.csN && !pins.sck && !pins.mosi && status == '0)
		else begin failCount++; $error("pins or status wrong after reset"); end

	busyLength: assert property (@(posedge clk) disable iff (!rstN)
		$fell(status.busy) |-> busyLen == spiPkg::xferCycles)
		else begin failCount++; $error("busy did not last 16 cycles"); end

	eightEdges: assert property (@(posedge clk) disable iff (!rstN)
		$fell(status.busy) |-> sckEdges == spiPkg::xferCycles / 2)
		else begin failCount++; $error("transfer did not give 8 SCK edges"); end

	mosiWhileLow: assert property (@(posedge clk) disable iff (!rstN)
		$changed(pins.mosi) |-> !pins.sck)
		else begin failCount++; $error("MOSI moved while SCK high"); end

	csHeld: assert property (@(posedge clk) disable iff (!rstN)
		status.busy && $past(status.busy) |-> $stable(pins.csN))
		else begin failCount++; $error("csN changed during a transfer"); end

	quietDeselected: assert property (@(posedge clk) disable iff (!rstN)
		pins.csN |-> !status.busy)
		else begin failCount++; $error("busy while the flash is deselected"); end

	rxHeld: assert property (@(posedge clk) disable iff (!rstN)
		!status.busy && !$past(status.busy) |-> $stable(status.rxByte))
		else begin failCount++; $error("received byte changed while idle"); end

endmodule

//--- spiTb.sv
/*
 * spiTb
 * Testbench of the SPI flash master. CPU bus writes and reads go out on
 * falling clk edges against a W25Q16BV model. Covers JEDEC ID, random
 * address reads, deselect, dropped writes and reads of other addresses.
 */
`timescale 1ns/1ps

module spiTb;

	localparam int         clkPeriod         = 40;
	localparam int         pollLimit         = 40;    // busy lasts 16 cycles
	localparam int         transferBudget    = 20;
	localparam int         cyclesPerTransfer = 20;
	localparam int         marginCycles      = 200;
	localparam logic [7:0] opRead            = 8'h03;
	localparam logic [7:0] opJedec           = 8'h9F;

	logic                clk;
	logic                rstN;
	logic                memWrite;
	logic                miso;
	hackBusPkg::hackAddr memAddr;
	hackBusPkg::hackWord memWData;
	hackBusPkg::hackWord memRData;
	spiPkg::spiPins      pins;
	spiPkg::spiByte      flashLastByte;
	int                  flashByteCount;
	int                  mismatches  = 0;
	int                  otherErrors = 0;

	tbClock uClock (.clk(clk), .rstN(rstN));

	flashSpiTop DUT (
		.clk      (clk),
		.rstN     (rstN),
		.memWrite (memWrite),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memRData (memRData),
		.miso     (miso),
		.pins     (pins)
	);

	flashModel uFlash (
		.pins      (pins),
		.miso      (miso),
		.lastByte  (flashLastByte),
		.byteCount (flashByteCount)
	);

	bind flashSpiTop spiProperties uProps (.clk(clk), .rstN(rstN), .pins(pins), .status(status));

	function automatic spiPkg::spiByte patternByte(input logic [23:0] addr);
		return addr[7:0] ^ 8'hA5;   // model data at a flash address
	endfunction

	function automatic spiPkg::spiByte jedecIdByte(input int idx);
		return (idx == 0) ? 8'hEF : (idx == 1) ? 8'h40 : 8'h15;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (expected == actual) else begin
			mismatches++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic writeReg(input hackBusPkg::hackAddr addr, input hackBusPkg::hackWord data);
		@(negedge clk);
		memAddr  = addr;
		memWData = data;
		memWrite = 1'b1;
		@(negedge clk);
		memWrite = 1'b0;   // one-cycle strobe
	endtask

	task automatic readReg(input hackBusPkg::hackAddr addr, output hackBusPkg::hackWord data);
		@(negedge clk);
		memAddr = addr;
		#(clkPeriod / 4);   // mid low phase, read data settled
		data = memRData;
	endtask

	task automatic waitIdle(output hackBusPkg::hackWord word);
		int polls;
		polls = 0;
		do begin
			readReg(hackBusPkg::spiRegAddr, word);
			polls++;
		end while (word[15] && polls < pollLimit);
		if (word[15]) begin
			otherErrors++;
			$display("ERROR: busy still set after %0d polls of the SPI register", polls);
		end
	endtask

	// one byte out and in, optional send and deselect landing mid-transfer
	task automatic sendByte(input string name, input spiPkg::spiByte txByte,
			input logic dropWrite, output spiPkg::spiByte rxByte);
		hackBusPkg::hackWord word;
		int                  countBefore;
		countBefore = flashByteCount;
		writeReg(hackBusPkg::spiRegAddr, {8'h00, txByte});   // bit 8 low selects
		if (dropWrite) begin
			repeat (4) @(negedge clk);
			writeReg(hackBusPkg::spiRegAddr, 16'h005A);
			writeReg(hackBusPkg::spiRegAddr, 16'h0100);   // would raise csN mid-byte
		end
		waitIdle(word);
		checkValue({name, " mosi"}, 16'(txByte), 16'(flashLastByte));
		checkValue({name, " byte count"}, 16'(countBefore + 1), 16'(flashByteCount));
		rxByte = word[7:0];
	endtask

	task automatic deselect();
		hackBusPkg::hackWord word;
		writeReg(hackBusPkg::spiRegAddr, 16'h0100);
		readReg(hackBusPkg::spiRegAddr, word);
		checkValue("deselect busy", 16'h0000, 16'(word[15]));
		checkValue("deselect csN", 16'h0001, 16'(pins.csN));
	endtask

	task automatic readOtherAddresses(input int count);
		hackBusPkg::hackAddr addr;
		hackBusPkg::hackWord word;
		repeat (count) begin
			addr = hackBusPkg::hackAddr'($urandom());
			if (addr == hackBusPkg::spiRegAddr) begin
				addr = addr ^ 15'h0001;   // stay off the SPI register
			end
			readReg(addr, word);
			checkValue($sformatf("read of %h", addr), 16'h0000, word);
		end
	endtask

	task automatic finishRun();
		int assertFails;
		assertFails = DUT.uProps.failCount;
		$display("errors: %0d mismatches, %0d assertion failures, %0d other",
			mismatches, assertFails, otherErrors);
		if (mismatches + assertFails + otherErrors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	initial begin
		#(transferBudget * cyclesPerTransfer * clkPeriod + marginCycles * clkPeriod);
		otherErrors++;
		$display("ERROR: watchdog expired before the test sequence completed");
		finishRun();
	end

	initial begin
		hackBusPkg::hackWord word;
		spiPkg::spiByte      rx;
		logic [23:0]         readAddr;
		memWrite = 1'b0;
		memAddr  = '0;
		memWData = '0;
		void'($urandom(32'h2e34_7f11));
		@(posedge rstN);
		readReg(hackBusPkg::spiRegAddr, word);
		checkValue("reset status", 16'h0000, word);
		checkValue("reset csN", 16'h0001, 16'(pins.csN));

		// JEDEC ID, three bytes clocked out with dummies
		sendByte("jedec opcode", opJedec, 1'b0, rx);
		for (int i = 0; i < 3; i++) begin
			sendByte("jedec dummy", 8'h00, 1'b0, rx);
			checkValue($sformatf("jedec id byte %0d", i), 16'(jedecIdByte(i)), 16'(rx));
		end
		deselect();

		// read data at a random address, third dummy gets writes while busy
		readAddr = 24'($urandom());
		sendByte("read opcode", opRead, 1'b0, rx);
		sendByte("read addr high", readAddr[23:16], 1'b0, rx);
		sendByte("read addr mid", readAddr[15:8], 1'b0, rx);
		sendByte("read addr low", readAddr[7:0], 1'b0, rx);
		for (int i = 0; i < 4; i++) begin
			sendByte("read dummy", 8'h00, i == 2, rx);
			checkValue($sformatf("read data %0d", i), 16'(patternByte(readAddr + 24'(i))),
				16'(rx));
		end
		deselect();

		// decode restarts after deselect
		sendByte("restart opcode", opJedec, 1'b0, rx);
		sendByte("restart dummy", 8'h00, 1'b0, rx);
		checkValue("restart jedec byte", 16'h00EF, 16'(rx));
		deselect();
		readOtherAddresses(4);   // status now nonzero, must not leak

		repeat (3) begin
			sendByte("random send", 8'($urandom()), 1'b0, rx);
		end
		deselect();
		finishRun();
	end

endmodule

//--- project.f
hackBusPkg.sv
spiPkg.sv
spiBitTimer.sv
spiShifter.sv
spiController.sv
spiBusPort.sv
flashSpiTop.sv
tbClock.sv
flashModel.sv
spiProperties_properties.sv
spiTb.sv

//--- Makefile
# Verilator build and run of the SPI flash master testbench

VERILATOR ?= verilator
TOP       ?= spiTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
RUNFLAGS  ?= +verilator+error+limit+1000
PASSMSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASSMSG)$$" $(LOG) || (echo "no pass message found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
